// ==== hw/csr_macros.svh ====
// Build options for the CSR file. CSR_XLEN must stay 32, and CSR_W_COUNTER must lie in 1..64
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// ------------------------------
// Data path
// ------------------------------

`define CSR_XLEN 32 // Width of one CSR word, RV32 only

// ------------------------------
// Counters
// ------------------------------

// Low bits of mcycle/minstret that count in hardware
// Upper bits stay writable, so software can extend a narrow counter
`define CSR_W_COUNTER 64

// ------------------------------
// ISA extensions seen in misa
// ------------------------------

`define CSR_EXT_M 0 // 1 when the core has mul/div
`define CSR_EXT_C 0 // 1 when the core has compressed instructions

`endif

// ==== hw/csr_pkg.sv ====
// Types, CSR addresses and the write-update rule shared by the CSR file. Machine mode only, RV32
`include "csr_macros.svh"

package csr_pkg;

	// ------------------------------
	// Vector types
	// ------------------------------

	typedef logic [11:0]             csr_addr_t; // CSR address from the instruction
	typedef logic [`CSR_XLEN-1:0]    xlen_t;     // One CSR data word
	typedef logic [2*`CSR_XLEN-1:0]  counter_t;  // Full 64-bit counter value

	// ------------------------------
	// Write kind and register select
	// ------------------------------

	typedef enum logic [1:0] {
		CSR_WTYPE_W = 2'h0, // CSRRW, plain write
		CSR_WTYPE_S = 2'h1, // CSRRS, set bits
		CSR_WTYPE_C = 2'h2  // CSRRC, clear bits
	} csr_wtype_e;

	typedef enum logic [3:0] {
		SEL_NONE,     // Unmapped, reads zero
		SEL_MISA,
		SEL_ID,       // mvendorid/marchid/mimpid/mhartid
		SEL_MSTATUS,
		SEL_MTVEC,
		SEL_MSCRATCH,
		SEL_INHIBIT,  // mcountinhibit
		SEL_CYCLE,    // mcycle and mtime
		SEL_CYCLEH,   // mcycleh and mtimeh
		SEL_INSTRET,
		SEL_INSTRETH
	} csr_sel_e;

	// Access request, strobes last one cycle
	typedef struct packed {
		csr_addr_t  addr;
		xlen_t      wdata;
		csr_wtype_e wtype;
		logic       wen;
		logic       ren;
	} csr_req_t;

	// ------------------------------
	// Mapped CSR addresses
	// ------------------------------

	localparam csr_addr_t CSR_MVENDORID     = 12'hf11; // Read only
	localparam csr_addr_t CSR_MARCHID       = 12'hf12; // Read only
	localparam csr_addr_t CSR_MIMPID        = 12'hf13; // Read only
	localparam csr_addr_t CSR_MHARTID       = 12'hf14; // Read only
	localparam csr_addr_t CSR_MSTATUS       = 12'h300;
	localparam csr_addr_t CSR_MISA          = 12'h301;
	localparam csr_addr_t CSR_MTVEC         = 12'h305;
	localparam csr_addr_t CSR_MCOUNTINHIBIT = 12'h320; // Tied zero, mtime aliases mcycle
	localparam csr_addr_t CSR_MSCRATCH      = 12'h340;
	localparam csr_addr_t CSR_MCYCLE        = 12'hb00;
	localparam csr_addr_t CSR_MTIME         = 12'hb01;
	localparam csr_addr_t CSR_MINSTRET      = 12'hb02;
	localparam csr_addr_t CSR_MCYCLEH       = 12'hb80;
	localparam csr_addr_t CSR_MTIMEH        = 12'hb81;
	localparam csr_addr_t CSR_MINSTRETH     = 12'hb82;

	// New value of a CSR word after a write, set or clear
	function automatic xlen_t csr_update(xlen_t old_val, xlen_t wdata, csr_wtype_e wtype);
		case (wtype)
			CSR_WTYPE_S: return old_val | wdata;  // Set bits
			CSR_WTYPE_C: return old_val & ~wdata; // Clear bits
			default:     return wdata;            // Plain write
		endcase
	endfunction

endpackage

// ==== hw/csr_decode.sv ====
// CSR address decoder. Purely combinational; HPM counters, medeleg and mideleg are not decoded
`timescale 1ns/10ps

module csr_decode import csr_pkg::*; (
	input  csr_addr_t addr,
	input  logic      wen,
	input  logic      ren,
	output csr_sel_e  sel,
	output logic      wr_scratch,
	output logic      wr_cyc_lo,
	output logic      wr_cyc_hi,
	output logic      wr_ret_lo,
	output logic      wr_ret_hi,
	output logic      error
);

	logic match;  // Address hits a mapped CSR
	logic ro_id;  // Address is one of the read-only ID registers
	logic legal;  // Access may go ahead

	// ------------------------------
	// Address to register select
	// ------------------------------

	always_comb begin
		sel   = SEL_NONE; // Unmapped by default
		match = 1'b0;
		ro_id = 1'b0;
		case (addr)
			CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID: begin
				sel   = SEL_ID;
				match = 1'b1;
				ro_id = 1'b1; // Writes trap
			end
			CSR_MISA: begin
				sel   = SEL_MISA;
				match = 1'b1;
			end
			CSR_MSTATUS: begin
				sel   = SEL_MSTATUS; // Writes accepted, no effect
				match = 1'b1;
			end
			CSR_MTVEC: begin
				sel   = SEL_MTVEC;
				match = 1'b1;
			end
			CSR_MSCRATCH: begin
				sel   = SEL_MSCRATCH;
				match = 1'b1;
			end
			CSR_MCOUNTINHIBIT: begin
				sel   = SEL_INHIBIT;
				match = 1'b1;
			end
			CSR_MCYCLE, CSR_MTIME: begin
				sel   = SEL_CYCLE; // mtime is the cycle count
				match = 1'b1;
			end
			CSR_MCYCLEH, CSR_MTIMEH: begin
				sel   = SEL_CYCLEH;
				match = 1'b1;
			end
			CSR_MINSTRET: begin
				sel   = SEL_INSTRET;
				match = 1'b1;
			end
			CSR_MINSTRETH: begin
				sel   = SEL_INSTRETH;
				match = 1'b1;
			end
			default: ; // HPMs and delegation registers land here
		endcase
	end

	// ------------------------------
	// Error and write strobes
	// ------------------------------

	assign legal = match && !(wen && ro_id);      // Write to an ID register is illegal
	assign error = (wen || ren) && !legal;        // Low when idle

	assign wr_scratch = wen && legal && (sel == SEL_MSCRATCH);
	assign wr_cyc_lo  = wen && legal && (sel == SEL_CYCLE);
	assign wr_cyc_hi  = wen && legal && (sel == SEL_CYCLEH);
	assign wr_ret_lo  = wen && legal && (sel == SEL_INSTRET);
	assign wr_ret_hi  = wen && legal && (sel == SEL_INSTRETH);

endmodule

// ==== hw/csr_counter.sv ====
// 64-bit event counter; only the low W_COUNTER bits count, the upper bits change only on a write
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_counter import csr_pkg::*; #(
	parameter int W_COUNTER = `CSR_W_COUNTER // 1..64
) (
	input  logic     clk,
	input  logic     rst_n,
	input  csr_req_t req,
	input  logic     inc,
	input  logic     wr_lo,
	input  logic     wr_hi,
	output counter_t count
);

	localparam int XLEN = `CSR_XLEN;

	// Ones over the bits that count, shift by 64 leaves the full mask
	localparam counter_t INC_MASK = ~({$bits(counter_t){1'b1}} << W_COUNTER);

	counter_t count_q;
	counter_t count_inc; // Value after this cycle's increment
	xlen_t    lo_nxt;
	xlen_t    hi_nxt;

	// ------------------------------
	// Next value
	// ------------------------------

	always_comb begin
		count_inc = count_q;
		if (inc)
			count_inc = ((count_q + 1'b1) & INC_MASK) | (count_q & ~INC_MASK); // Top bits hold
	end

	// A written half takes the update from its old value, the other keeps counting
	assign lo_nxt = wr_lo ? csr_update(count_q[XLEN-1:0], req.wdata, req.wtype)
	                      : count_inc[XLEN-1:0];
	assign hi_nxt = wr_hi ? csr_update(count_q[2*XLEN-1:XLEN], req.wdata, req.wtype)
	                      : count_inc[2*XLEN-1:XLEN];

	// ------------------------------
	// State
	// ------------------------------

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count_q <= '0;
		end else begin
			count_q <= {hi_nxt, lo_nxt};
		end
	end

	assign count = count_q;

endmodule

// ==== hw/csr_reg_bank.sv ====
// CSR storage and read mux; only mscratch is stored here, misa comes from the build macros
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_reg_bank import csr_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  csr_req_t req,
	input  csr_sel_e sel,
	input  logic     wr_scratch,
	input  counter_t cycle,
	input  counter_t instret,
	output xlen_t    rdata
);

	localparam int XLEN = `CSR_XLEN;

	// ------------------------------
	// Constant registers
	// ------------------------------

	localparam xlen_t MISA_VAL = {
		2'b01,                  // MXL, 32-bit
		4'd0,
		13'd0,                  // Z..N absent
		1'(`CSR_EXT_M != 0),    // M
		3'd0,                   // L..J absent
		1'b1,                   // I, base integer ISA
		5'd0,                   // H..D absent
		1'(`CSR_EXT_C != 0),    // C
		2'd0                    // B, A absent
	};

	localparam xlen_t MSTATUS_VAL = 32'h0000_1800; // MPP = 3, MIE/MPIE tied off
	localparam xlen_t MTVEC_VAL   = 32'h0000_0001; // Vectored mode, base zero

	// ------------------------------
	// mscratch
	// ------------------------------

	xlen_t mscratch;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mscratch <= '0;
		end else if (wr_scratch) begin
			mscratch <= csr_update(mscratch, req.wdata, req.wtype); // Seen next cycle
		end
	end

	// ------------------------------
	// Read mux
	// ------------------------------

	always_comb begin
		case (sel)
			SEL_MISA:     rdata = MISA_VAL;
			SEL_MSTATUS:  rdata = MSTATUS_VAL;
			SEL_MTVEC:    rdata = MTVEC_VAL;
			SEL_MSCRATCH: rdata = mscratch;
			SEL_CYCLE:    rdata = cycle[XLEN-1:0];          // Also mtime
			SEL_CYCLEH:   rdata = cycle[2*XLEN-1:XLEN];     // Also mtimeh
			SEL_INSTRET:  rdata = instret[XLEN-1:0];
			SEL_INSTRETH: rdata = instret[2*XLEN-1:XLEN];
			SEL_ID,
			SEL_INHIBIT:  rdata = '0;                       // Tied zero
			default:      rdata = '0;                       // Unmapped
		endcase
	end

endmodule

// ==== hw/csr_file_top.sv ====
// Machine-mode CSR file top. Same-cycle read, write lands on the next edge, no back-pressure
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_file_top import csr_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  csr_req_t req,
	input  logic     instr_ret,
	output xlen_t    rdata,
	output logic     error
);

	csr_sel_e sel;
	logic     wr_scratch;
	logic     wr_cyc_lo;
	logic     wr_cyc_hi;
	logic     wr_ret_lo;
	logic     wr_ret_hi;
	counter_t cycle;
	counter_t instret;

	// ------------------------------
	// Decode
	// ------------------------------

	csr_decode u_decode (
		.addr       (req.addr),
		.wen        (req.wen),
		.ren        (req.ren),
		.sel        (sel),
		.wr_scratch (wr_scratch),
		.wr_cyc_lo  (wr_cyc_lo),
		.wr_cyc_hi  (wr_cyc_hi),
		.wr_ret_lo  (wr_ret_lo),
		.wr_ret_hi  (wr_ret_hi),
		.error      (error)
	);

	// ------------------------------
	// Counters
	// ------------------------------

	csr_counter #(.W_COUNTER(`CSR_W_COUNTER)) u_cycle (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.inc   (1'b1),        // Counts every clock
		.wr_lo (wr_cyc_lo),
		.wr_hi (wr_cyc_hi),
		.count (cycle)
	);

	csr_counter #(.W_COUNTER(`CSR_W_COUNTER)) u_instret (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.inc   (instr_ret),   // One per retired instruction
		.wr_lo (wr_ret_lo),
		.wr_hi (wr_ret_hi),
		.count (instret)
	);

	// Storage and read data
	csr_reg_bank u_bank (
		.clk        (clk),
		.rst_n      (rst_n),
		.req        (req),
		.sel        (sel),
		.wr_scratch (wr_scratch),
		.cycle      (cycle),
		.instret    (instret),
		.rdata      (rdata)
	);

endmodule

// ==== sim/csr_chk.sv ====
// Bound port checker; the mcycleh/mtimeh hold check assumes the low half does not wrap between reads
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_chk import csr_pkg::*; (
	input logic     clk,
	input logic     rst_n,
	input csr_req_t req,
	input xlen_t    rdata,
	input logic     error
);

	localparam xlen_t MISA_EXP = 32'h4000_0100          // MXL of 1 with I present
		| ((`CSR_EXT_M != 0) ? 32'h0000_1000 : 32'h0) // M
		| ((`CSR_EXT_C != 0) ? 32'h0000_0004 : 32'h0); // C

	int    fail_count = 0; // Failed assertion count
	xlen_t scratch_exp;    // Expected mscratch
	logic  mapped;         // Address is a kept CSR
	logic  id_addr;        // Read-only ID register
	logic  const_rd;       // Plain read of a constant CSR
	logic  cyc_rd;         // Plain read of mcycle or mtime
	logic  cych_rd;        // Plain read of mcycleh or mtimeh
	logic  cyc_wr;         // Write to mcycle or mtime

	// ------------------------------
	// Expected values
	// ------------------------------

	function automatic xlen_t apply_write(xlen_t cur, xlen_t data, csr_wtype_e kind);
		return (kind == CSR_WTYPE_S) ? (cur | data) : (kind == CSR_WTYPE_C) ? (cur & ~data) : data;
	endfunction

	// Low half after one count with bits at and above CSR_W_COUNTER held
	function automatic xlen_t next_low(xlen_t v);
		xlen_t mask;
		mask = (`CSR_W_COUNTER >= 32) ? '1 : xlen_t'((64'd1 << `CSR_W_COUNTER) - 64'd1);
		return (v & ~mask) | ((v + 32'd1) & mask);
	endfunction

	function automatic xlen_t const_value(csr_addr_t addr);
		case (addr)
			CSR_MISA:    return MISA_EXP;
			CSR_MSTATUS: return 32'h0000_1800; // MPP = 3
			CSR_MTVEC:   return 32'h0000_0001; // Vectored mode with base zero
			default:     return '0;            // IDs and mcountinhibit
		endcase
	endfunction

	assign mapped = req.addr inside {CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID,
		CSR_MSTATUS, CSR_MISA, CSR_MTVEC, CSR_MCOUNTINHIBIT, CSR_MSCRATCH, CSR_MCYCLE,
		CSR_MTIME, CSR_MINSTRET, CSR_MCYCLEH, CSR_MTIMEH, CSR_MINSTRETH};
	assign id_addr  = req.addr inside {CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID, CSR_MHARTID};
	assign const_rd = req.ren && !req.wen
		&& (id_addr || req.addr inside {CSR_MISA, CSR_MSTATUS, CSR_MTVEC, CSR_MCOUNTINHIBIT});
	assign cyc_rd  = req.ren && !req.wen && req.addr inside {CSR_MCYCLE, CSR_MTIME};
	assign cych_rd = req.ren && !req.wen && req.addr inside {CSR_MCYCLEH, CSR_MTIMEH};
	assign cyc_wr  = req.wen && req.addr inside {CSR_MCYCLE, CSR_MTIME};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			scratch_exp <= '0;
		else if (req.wen && req.addr == CSR_MSCRATCH)
			scratch_exp <= apply_write(scratch_exp, req.wdata, req.wtype); // Seen next cycle
	end

	// ------------------------------
	// Assertions
	// ------------------------------

	const_read: assert property (@(posedge clk) disable iff (!rst_n)
		const_rd |-> rdata == const_value(req.addr) && !error) else begin
		fail_count++;
		$error("CHECK FAILED at %0t: constant CSR %h read %h", $time,
			$sampled(req.addr), $sampled(rdata));
	end

	scratch_read: assert property (@(posedge clk) disable iff (!rst_n)
		req.ren && req.addr == CSR_MSCRATCH |-> rdata == scratch_exp) else begin
		fail_count++;
		$error("CHECK FAILED at %0t: mscratch read %h, expected %h", $time,
			$sampled(rdata), $sampled(scratch_exp));
	end

	error_expected: assert property (@(posedge clk) disable iff (!rst_n)
		((req.ren || req.wen) && !mapped) || (req.wen && id_addr) |-> error && rdata == '0)
	else begin
		fail_count++;
		$error("CHECK FAILED at %0t: illegal access to %h not flagged", $time,
			$sampled(req.addr));
	end

	error_absent: assert property (@(posedge clk) disable iff (!rst_n)
		(!req.ren && !req.wen) || (req.ren && !req.wen && mapped) |-> !error) else begin
		fail_count++;
		$error("CHECK FAILED at %0t: error raised on legal or idle cycle, addr %h", $time,
			$sampled(req.addr));
	end

	cycle_step: assert property (@(posedge clk) disable iff (!rst_n)
		cyc_rd && $past(cyc_rd) |-> rdata == next_low($past(rdata))) else begin
		fail_count++;
		$error("CHECK FAILED at %0t: mcycle did not advance by one, read %h", $time,
			$sampled(rdata));
	end

	cycle_high_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cych_rd && $past(cych_rd) |-> rdata == $past(rdata)) else begin
		fail_count++;
		$error("CHECK FAILED at %0t: mtimeh and mcycleh differ, read %h", $time,
			$sampled(rdata));
	end

	cycle_write: assert property (@(posedge clk) disable iff (!rst_n)
		cyc_wr |=> !cyc_rd
		|| rdata == apply_write($past(rdata), $past(req.wdata), csr_wtype_e'($past(req.wtype))))
	else begin
		fail_count++;
		$error("CHECK FAILED at %0t: mcycle read %h after write", $time, $sampled(rdata));
	end

endmodule

// ==== sim/csr_tb.sv ====
// CSR file testbench; per-cycle checks sit in the bound checker and final model values are compared here
`timescale 1ns/10ps
`include "csr_macros.svh"

module csr_tb import csr_pkg::*; ();

	localparam int          STIM_CYCLES     = 1000;          // Rough stimulus length
	localparam int          WATCHDOG_CYCLES = 2 * STIM_CYCLES;
	localparam int          N_SCRATCH       = 400;           // Random mscratch operations
	localparam int          N_RET           = 500;           // Cycles of random instr_ret
	localparam logic [31:0] SEED            = 32'h2984_6fd5;
	localparam csr_addr_t   MEDELEG         = 12'h302;       // Not decoded
	localparam csr_addr_t   MHPMCOUNTER3    = 12'hb03;       // Not decoded
	localparam csr_addr_t   CONST_ADDRS [8] = '{CSR_MISA, CSR_MVENDORID, CSR_MARCHID, CSR_MIMPID,
		CSR_MHARTID, CSR_MSTATUS, CSR_MTVEC, CSR_MCOUNTINHIBIT};

	logic     clk;
	logic     rst_n;
	csr_req_t req;
	logic     instr_ret;
	xlen_t    rdata;
	logic     error;

	xlen_t    scratch_model; // Expected mscratch
	counter_t ret_model;     // Expected minstret
	int       check_errors;
	int       assert_errors;

	csr_file_top dut0 (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.instr_ret (instr_ret),
		.rdata     (rdata),
		.error     (error)
	);

	bind csr_file_top csr_chk u_chk (
		.clk   (clk),
		.rst_n (rst_n),
		.req   (req),
		.rdata (rdata),
		.error (error)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// ------------------------------
	// Models and helpers
	// ------------------------------

	function automatic xlen_t apply_write(xlen_t cur, xlen_t data, csr_wtype_e kind);
		return (kind == CSR_WTYPE_S) ? (cur | data) : (kind == CSR_WTYPE_C) ? (cur & ~data) : data;
	endfunction

	// One count where only the low CSR_W_COUNTER bits move
	function automatic counter_t bump(counter_t v);
		counter_t mask;
		mask = (`CSR_W_COUNTER >= 64) ? '1 : ((counter_t'(1) << `CSR_W_COUNTER) - counter_t'(1));
		return (v & ~mask) | ((v + counter_t'(1)) & mask);
	endfunction

	// One request cycle driven on the rising edge
	task automatic drive(input csr_addr_t target, input logic rd, input logic wr,
			input xlen_t data, input csr_wtype_e kind, input logic ret);
		@(posedge clk);
		req       <= '{addr: target, wdata: data, wtype: kind, wen: wr, ren: rd};
		instr_ret <= ret;
	endtask

	task automatic read_csr(input csr_addr_t target, output xlen_t val);
		drive(target, 1'b1, 1'b0, '0, CSR_WTYPE_W, 1'b0);
		@(negedge clk); // Settled combinational read
		val = rdata;
	endtask

	task automatic compare_value(input string what, input xlen_t got, input xlen_t exp);
		if (got !== exp) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	// ------------------------------
	// Stimulus
	// ------------------------------

	initial begin
		xlen_t      val;
		xlen_t      hi;
		xlen_t      wd;
		csr_wtype_e kind;
		logic       pulse;
		void'($urandom(SEED));
		req           = '0;
		instr_ret     = 1'b0;
		rst_n         = 1'b0;
		check_errors  = 0;
		scratch_model = '0;
		ret_model     = '0;
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;
		read_csr(CSR_MSCRATCH, val);                 // Reset values
		compare_value("mscratch after reset", val, '0);
		read_csr(CSR_MINSTRET, val);
		compare_value("minstret after reset", val, '0);
		foreach (CONST_ADDRS[i])
			read_csr(CONST_ADDRS[i], val);           // Constant CSRs
		for (int i = 0; i < N_SCRATCH; i++) begin
			wd    = $urandom;
			kind  = csr_wtype_e'($urandom % 3);
			pulse = 1'($urandom % 2);
			drive(CSR_MSCRATCH, 1'b1, 1'b1, wd, kind, pulse); // Read old and write new
			scratch_model = apply_write(scratch_model, wd, kind);
			if (pulse)
				ret_model = bump(ret_model);
		end
		read_csr(CSR_MSCRATCH, val);
		compare_value("mscratch after random writes", val, scratch_model);
		read_csr(MEDELEG, val);                      // Error cases
		drive(MHPMCOUNTER3, 1'b0, 1'b1, $urandom, CSR_WTYPE_W, 1'b0);
		drive(CSR_MVENDORID, 1'b0, 1'b1, '1, CSR_WTYPE_W, 1'b0);
		read_csr(CSR_MVENDORID, val);
		compare_value("mvendorid after write", val, '0);
		drive(CSR_MSTATUS, 1'b0, 1'b1, '1, CSR_WTYPE_W, 1'b0); // Ignored
		read_csr(CSR_MSTATUS, val);
		drive('0, 1'b0, 1'b0, '0, CSR_WTYPE_W, 1'b0);
		read_csr(CSR_MCYCLE, val);                   // Cycle counter
		read_csr(CSR_MTIME, val);
		read_csr(CSR_MCYCLE, val);
		wd = $urandom | 32'h1;
		drive(CSR_MCYCLEH, 1'b0, 1'b1, wd, CSR_WTYPE_W, 1'b0); // Nonzero high half
		read_csr(CSR_MCYCLEH, val);
		read_csr(CSR_MTIMEH, val);
		wd = $urandom;
		drive(CSR_MCYCLE, 1'b0, 1'b1, wd, CSR_WTYPE_W, 1'b0);
		read_csr(CSR_MCYCLE, val);
		read_csr(CSR_MTIME, val);
		for (int i = 0; i < N_RET; i++) begin
			pulse = 1'($urandom % 2);
			drive('0, 1'b0, 1'b0, '0, CSR_WTYPE_W, pulse);
			if (pulse)
				ret_model = bump(ret_model);
		end
		read_csr(CSR_MINSTRET, val);
		read_csr(CSR_MINSTRETH, hi);
		compare_value("minstret low after pulses", val, ret_model[31:0]);
		compare_value("minstret high after pulses", hi, ret_model[63:32]);
		drive(CSR_MINSTRET, 1'b0, 1'b1, '1, CSR_WTYPE_W, 1'b0); // Carry into high half
		ret_model[31:0] = '1;
		drive('0, 1'b0, 1'b0, '0, CSR_WTYPE_W, 1'b1);
		ret_model = bump(ret_model);
		read_csr(CSR_MINSTRET, val);
		read_csr(CSR_MINSTRETH, hi);
		compare_value("minstret low after carry", val, ret_model[31:0]);
		compare_value("minstret high after carry", hi, ret_model[63:32]);
		drive('0, 1'b0, 1'b0, '0, CSR_WTYPE_W, 1'b0);
		repeat (2) @(negedge clk); // Last assertion edge has passed
		assert_errors = dut0.u_chk.fail_count;
		$display("Errors: %0d value checks, %0d assertions", check_errors, assert_errors);
		if (check_errors == 0 && assert_errors == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("TIMEOUT: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Errors: %0d value checks, %0d assertions", check_errors, dut0.u_chk.fail_count);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

// ==== files.f ====
+incdir+hw
hw/csr_pkg.sv
hw/csr_decode.sv
hw/csr_counter.sv
hw/csr_reg_bank.sv
hw/csr_file_top.sv
sim/csr_chk.sv
sim/csr_tb.sv

// ==== Bender.yml ====
package:
  name: csr_file

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/csr_pkg.sv
      - hw/csr_decode.sv
      - hw/csr_counter.sv
      - hw/csr_reg_bank.sv
      - hw/csr_file_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/csr_chk.sv
      - sim/csr_tb.sv
